// ==== csr_index_configure.f ====
+incdir+verif
common/csr_mem_pkg.sv
common/csr_engine_pkg.sv
common/csr_stream_if.sv
hdl/csr_sync_fifo.sv
csr_index_configure/csr_response_filter.sv
csr_index_configure/csr_config_assembler.sv
hdl/csr_index_configure_top.sv
verif/csr_index_configure_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the CSR index configuration unit

TOP = csr_index_configure_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f csr_index_configure.f -o sim

# Pass or fail is decided by the log, not by the simulator exit code
run: build
	./obj_dir/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f csr_index_configure.f

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/csr_index_configure_checks.svh ====
// Stimulus, reference model and compare tasks for the configuration unit testbench.
// Included inside the testbench module, so the tasks drive and read its signals.

`ifndef CSR_INDEX_CONFIGURE_CHECKS_SVH
`define CSR_INDEX_CONFIGURE_CHECKS_SVH

// --------------------
// Compare tasks
// --------------------
task automatic check_bit(input string name, input logic actual, input logic expected);
    begin
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0t: %s is %b, expected %b",
                                     $time, name, actual, expected));
        end
    end
endtask

task automatic check_config(input string name,
                            input csr_engine_pkg::csr_index_config_t actual,
                            input csr_engine_pkg::csr_index_config_t expected);
    begin
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    end
endtask

// --------------------
// Reference record
// --------------------
// Field layout of each sequence word, later words overwrite earlier ones
task automatic decode_into_model(input int index, input logic [31:0] data);
    begin
        case (index)
            0: begin
                model_record.increment     = data[0];
                model_record.decrement     = data[1];
                model_record.mode_sequence = data[2];
                model_record.mode_buffer   = data[3];
            end
            1: model_record.index_start = data;
            2: model_record.index_end   = data;
            3: model_record.stride      = data;
            4: begin
                model_record.granularity = data[30:0];
                model_record.shift_right = data[31];
            end
            5: begin
                model_record.cmd    = csr_mem_pkg::memory_cmd_e'(data[1:0]);
                model_record.buffer = csr_mem_pkg::buffer_kind_e'(data[4:2]);
            end
            6: begin
                model_record.operand = csr_engine_pkg::engine_operand_e'(data[1:0]);
                model_record.filter  = csr_engine_pkg::filter_op_e'(data[4:2]);
                model_record.alu     = csr_engine_pkg::alu_op_e'(data[7:5]);
            end
            7: model_record.array_pointer[31:0]  = data;
            8: model_record.array_pointer[63:32] = data;
            9: model_record.array_size = data;
            default: begin
            end
        endcase
    end
endtask

// --------------------
// Drivers
// --------------------
// Called on a falling edge, returns on the falling edge after the transfer
task automatic send_word(input csr_mem_pkg::buffer_kind_e kind, input logic [31:0] offset,
                         input logic [4:0] shift, input logic [31:0] data);
    logic accepted;
    begin
        accepted        = 1'b0;
        response_valid  = 1'b1;
        response_buffer = kind;
        response_offset = offset;
        response_shift  = shift;
        response_data   = data;
        while (!accepted) begin
            // Ready only moves on rising edges, so this value holds at the next one
            accepted = response_ready;
            @(negedge ap_clk);
        end
        response_valid = 1'b0;
    end
endtask

// Setup word with random data, also applied to the reference record
task automatic send_setup_word(input int index, input logic [4:0] shift,
                               input csr_mem_pkg::buffer_kind_e kind);
    logic [31:0] data;
    begin
        data = $urandom();
        send_word(kind, index << shift, shift, data);
        decode_into_model(index, data);
    end
endtask

`endif

// ==== verif/csr_index_configure_tb.sv ====
// Directed testbench for the CSR index configuration unit.
// Sends response words to the top level and checks the records that come out.

`timescale 1ns/100ps
`default_nettype none

module csr_index_configure_tb;

    // Roughly 80 words of a cycle or two each plus drains and idle checks
    localparam int max_cycles = 4000;

    logic                              ap_clk;
    logic                              areset_csr_index_generator;
    logic                              response_valid;
    logic                              response_ready;
    csr_mem_pkg::buffer_kind_e         response_buffer;
    logic [csr_mem_pkg::offset_w-1:0]  response_offset;
    logic [csr_mem_pkg::shift_w-1:0]   response_shift;
    logic [csr_mem_pkg::data_w-1:0]    response_data;
    logic                              config_valid;
    logic                              config_ready;
    csr_engine_pkg::csr_index_config_t config_out;

    int                                cycle_count;
    csr_engine_pkg::csr_index_config_t model_record;
    // Records in the order the DUT must emit them
    csr_engine_pkg::csr_index_config_t expected_q [$];

    task automatic report_failure(input string what);
        begin
            $display("%s", what);
            $display(">>> FAIL");
            $fatal(1, "Run stopped at the first error");
        end
    endtask

    `include "csr_index_configure_checks.svh"

    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    csr_index_configure_top UUT (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_ready             (response_ready),
        .response_buffer            (response_buffer),
        .response_offset            (response_offset),
        .response_shift             (response_shift),
        .response_data              (response_data),
        .config_valid               (config_valid),
        .config_ready               (config_ready),
        .config_out                 (config_out)
    );

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        report_failure($sformatf("Timeout: the run did not finish in %0d cycles", max_cycles));
    end

    // --------------------
    // Output side
    // --------------------
    // Waits for a record and returns after the handshake edge
    task automatic receive_config();
        begin
            while (!config_valid) begin
                @(negedge ap_clk);
            end
            if (expected_q.size() == 0) begin
                report_failure("A configuration record came out that no test expected");
            end else begin
                check_config("config_out", config_out, expected_q.pop_front());
            end
            @(negedge ap_clk);
        end
    endtask

    task automatic expect_idle(input int cycles);
        begin
            repeat (cycles) begin
                check_bit("config_valid", config_valid, 1'b0);
                @(negedge ap_clk);
            end
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        begin
            check_bit("config_valid", config_valid, 1'b0);
            check_bit("response_ready", response_ready, 1'b1);
        end
    endtask

    task automatic test_in_order();
        begin
            for (int i = 0; i < csr_engine_pkg::seq_count; i++) begin
                send_setup_word(i, 5'd0, csr_mem_pkg::buf_cu_setup);
            end
            expected_q.push_back(model_record);
            receive_config();
        end
    endtask

    // Index 3 comes twice and the second stride must win
    task automatic test_shuffled_repeat();
        int order [11];
        begin
            order = '{5, 3, 0, 9, 1, 3, 7, 2, 8, 6, 4};
            foreach (order[i]) begin
                send_setup_word(order[i], 5'd3, csr_mem_pkg::buf_engine_setup);
            end
            expected_q.push_back(model_record);
            receive_config();
        end
    endtask

    // Every non-setup kind and every index from 10 to 15 goes by between valid words
    task automatic test_filtered_words();
        csr_mem_pkg::buffer_kind_e junk_kinds [4];
        begin
            junk_kinds = '{csr_mem_pkg::buf_invalid, csr_mem_pkg::buf_in_edges,
                           csr_mem_pkg::buf_out_edges, csr_mem_pkg::buf_auxiliary};
            for (int i = 0; i < csr_engine_pkg::seq_count; i++) begin
                send_setup_word(i, 5'd0, (i % 2 == 0) ? csr_mem_pkg::buf_cu_setup
                                                      : csr_mem_pkg::buf_engine_setup);
                send_word(junk_kinds[i % 4], i, 5'd0, $urandom());
                send_word(csr_mem_pkg::buf_cu_setup, (10 + i % 6) << 2, 5'd2, $urandom());
            end
            expected_q.push_back(model_record);
            receive_config();
            expect_idle(20);
        end
    endtask

    // Records pile up in the config FIFO until the consumer is ready
    task automatic test_backpressure();
        begin
            config_ready = 1'b0;
            for (int s = 0; s < 3; s++) begin
                for (int i = 0; i < csr_engine_pkg::seq_count; i++) begin
                    send_setup_word(i, 5'd1, csr_mem_pkg::buf_engine_setup);
                end
                expected_q.push_back(model_record);
            end
            check_bit("config_valid", config_valid, 1'b1);
            config_ready = 1'b1;
            repeat (3) begin
                receive_config();
            end
            expect_idle(10);
        end
    endtask

    initial begin
        void'($urandom(19));
        response_valid             = 1'b0;
        response_buffer            = csr_mem_pkg::buf_invalid;
        response_offset            = '0;
        response_shift             = '0;
        response_data              = '0;
        config_ready               = 1'b1;
        model_record               = '0;
        areset_csr_index_generator = 1'b1;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_index_generator = 1'b0;

        test_reset_state();
        test_in_order();
        test_shuffled_repeat();
        test_filtered_words();
        test_backpressure();

        $display(">>> PASS");
        $finish;
    end

endmodule : csr_index_configure_tb

`default_nettype wire

// ==== hdl/csr_index_configure_top.sv ====
// Top level of the CSR index configuration unit.
// Response stream in, configuration records out, both as valid/ready ports.

`timescale 1ns/100ps
`default_nettype none

module csr_index_configure_top (
    input  logic                              ap_clk,
    input  logic                              areset_csr_index_generator,
    input  logic                              response_valid,
    output logic                              response_ready,
    input  csr_mem_pkg::buffer_kind_e         response_buffer,
    input  logic [csr_mem_pkg::offset_w-1:0]  response_offset,
    input  logic [csr_mem_pkg::shift_w-1:0]   response_shift,
    input  logic [csr_mem_pkg::data_w-1:0]    response_data,
    output logic                              config_valid,
    input  logic                              config_ready,
    output csr_engine_pkg::csr_index_config_t config_out
);

    // --------------------
    // Streams
    // --------------------
    csr_stream_if #(.payload_t(csr_mem_pkg::seq_word_t))         response_words ();
    csr_stream_if #(.payload_t(csr_mem_pkg::seq_word_t))         word_stream ();
    csr_stream_if #(.payload_t(csr_engine_pkg::csr_index_config_t)) config_stream ();
    csr_stream_if #(.payload_t(csr_engine_pkg::csr_index_config_t)) config_fifo_out ();

    // Output port side of the config FIFO
    assign config_valid          = config_fifo_out.valid;
    assign config_out            = config_fifo_out.payload;
    assign config_fifo_out.ready = config_ready;
    // External consumer gives no early warning
    assign config_fifo_out.almost_full = 1'b0;

    // --------------------
    // Datapath
    // --------------------
    csr_response_filter u_response_filter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_buffer            (response_buffer),
        .response_offset            (response_offset),
        .response_shift             (response_shift),
        .response_data              (response_data),
        .response_ready             (response_ready),
        .words                      (response_words.source)
    );

    csr_sync_fifo #(
        .DEPTH (csr_engine_pkg::fifo_depth)
    ) u_response_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .in                         (response_words.sink),
        .out                        (word_stream.source)
    );

    csr_config_assembler u_config_assembler (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .words                      (word_stream.sink),
        .configs                    (config_stream.source)
    );

    csr_sync_fifo #(
        .DEPTH (csr_engine_pkg::fifo_depth)
    ) u_config_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .in                         (config_stream.sink),
        .out                        (config_fifo_out.source)
    );

endmodule : csr_index_configure_top

`default_nettype wire

// ==== csr_index_configure/csr_config_assembler.sv ====
// Builds a configuration record from the ten setup words of a sequence.
// Words may come in any order; the record is emitted once every index is seen.

`timescale 1ns/100ps
`default_nettype none

module csr_config_assembler (
    input  logic         ap_clk,
    input  logic         areset_csr_index_generator,
    csr_stream_if.sink   words,
    csr_stream_if.source configs
);

    csr_engine_pkg::seq_mask_t         seen;
    csr_engine_pkg::csr_index_config_t record;
    logic                              complete;
    logic                              take;
    logic [csr_mem_pkg::data_w-1:0]    data;

    // --------------------
    // Handshakes
    // --------------------
    assign complete = &seen;
    // Stall while a record waits or the config FIFO nears its threshold
    assign words.ready       = !complete && !configs.almost_full;
    assign words.almost_full = configs.almost_full;
    assign take              = words.valid && words.ready;
    assign data              = words.payload.data;

    assign configs.valid   = complete;
    assign configs.payload = record;

    // Seen mask clears when the record leaves
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            seen <= '0;
        end else if (configs.valid && configs.ready) begin
            seen <= '0;
        end else if (take) begin
            seen <= seen | (csr_engine_pkg::seq_mask_t'(1) << words.payload.seq_index);
        end
    end

    // --------------------
    // Field decode
    // --------------------
    // Last word for an index wins
    always_ff @(posedge ap_clk) begin
        if (take) begin
            case (words.payload.seq_index)
                4'd0: begin
                    record.increment     <= data[0];
                    record.decrement     <= data[1];
                    record.mode_sequence <= data[2];
                    record.mode_buffer   <= data[3];
                end
                4'd1: record.index_start <= data;
                4'd2: record.index_end   <= data;
                4'd3: record.stride      <= data;
                4'd4: begin
                    record.granularity <= data[csr_mem_pkg::data_w-2:0];
                    record.shift_right <= data[csr_mem_pkg::data_w-1];
                end
                4'd5: begin
                    record.cmd    <= csr_mem_pkg::memory_cmd_e'(data[1:0]);
                    record.buffer <= csr_mem_pkg::buffer_kind_e'(data[4:2]);
                end
                4'd6: begin
                    record.operand <= csr_engine_pkg::engine_operand_e'(data[1:0]);
                    record.filter  <= csr_engine_pkg::filter_op_e'(data[4:2]);
                    record.alu     <= csr_engine_pkg::alu_op_e'(data[7:5]);
                end
                // Pointer arrives as two halves
                4'd7: record.array_pointer[csr_mem_pkg::data_w-1:0] <= data;
                4'd8: begin
                    record.array_pointer[csr_mem_pkg::addr_w-1:csr_mem_pkg::data_w] <= data;
                end
                4'd9: record.array_size <= data;
                default: begin
                    record <= record;
                end
            endcase
        end
    end

    // --------------------
    // Checks
    // --------------------
    // No word lands in a record that is on offer
    a_no_take_when_complete : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        configs.valid |=> $stable(record));

    // Record stays put until the config FIFO accepts it
    a_record_held : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        configs.valid && !configs.ready |=> configs.valid && $stable(configs.payload));

endmodule : csr_config_assembler

`default_nettype wire

// ==== csr_index_configure/csr_response_filter.sv ====
// Input stage of the configuration unit.
// Registers each memory response and forwards only in-range setup words.

`timescale 1ns/100ps
`default_nettype none

module csr_response_filter (
    input  logic                             ap_clk,
    input  logic                             areset_csr_index_generator,
    input  logic                             response_valid,
    input  csr_mem_pkg::buffer_kind_e        response_buffer,
    input  logic [csr_mem_pkg::offset_w-1:0] response_offset,
    input  logic [csr_mem_pkg::shift_w-1:0]  response_shift,
    input  logic [csr_mem_pkg::data_w-1:0]   response_data,
    output logic                             response_ready,
    csr_stream_if.source                     words
);

    logic                             reg_valid;
    csr_mem_pkg::buffer_kind_e        reg_buffer;
    logic [csr_mem_pkg::offset_w-1:0] reg_offset;
    logic [csr_mem_pkg::shift_w-1:0]  reg_shift;
    logic [csr_mem_pkg::data_w-1:0]   reg_data;
    logic [csr_mem_pkg::offset_w-1:0] seq_full;
    logic                             setup_kind;
    logic                             keep;

    assign response_ready = words.ready;

    // --------------------
    // Filter
    // --------------------
    assign seq_full   = reg_offset >> reg_shift;
    assign setup_kind = (reg_buffer == csr_mem_pkg::buf_cu_setup) ||
                        (reg_buffer == csr_mem_pkg::buf_engine_setup);
    assign keep       = setup_kind && (seq_full < csr_engine_pkg::seq_count);

    assign words.valid   = reg_valid && keep;
    assign words.payload = '{seq_index: seq_full[csr_engine_pkg::seq_w-1:0], data: reg_data};

    // A kept word waits for the FIFO while dropped words clear
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            reg_valid <= 1'b0;
        end else if (response_ready) begin
            reg_valid <= response_valid;
        end else if (!keep) begin
            reg_valid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (response_valid && response_ready) begin
            reg_buffer <= response_buffer;
            reg_offset <= response_offset;
            reg_shift  <= response_shift;
            reg_data   <= response_data;
        end
    end

    // Every pushed word comes from a response whose full index is in range
    a_index_in_range : assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        response_valid && response_ready |=>
            !words.valid ||
            ($past(response_offset) >> $past(response_shift)) < csr_engine_pkg::seq_count);

    // A stalled word is offered again unchanged
    a_hold_on_stall : assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        words.valid && !words.ready |=> words.valid && $stable(words.payload));

endmodule : csr_response_filter

`default_nettype wire

// ==== hdl/csr_sync_fifo.sv ====
// Synchronous first-word-fall-through FIFO on valid/ready streams.
// Raises almost_full on its input side once occupancy reaches the threshold.

`timescale 1ns/100ps
`default_nettype none

module csr_sync_fifo #(
    parameter int DEPTH = csr_engine_pkg::fifo_depth
) (
    input  logic         ap_clk,
    input  logic         areset_csr_index_generator,
    csr_stream_if.sink   in,
    csr_stream_if.source out
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    logic [$bits(in.payload)-1:0] mem [DEPTH];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    logic   wr_en;
    logic   rd_en;

    // Pointer advance with wrap for any depth
    function automatic ptr_t ptr_next(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // --------------------
    // Flags and handshakes
    // --------------------
    assign in.ready       = (count != count_t'(DEPTH));
    assign in.almost_full = (count >= count_t'(csr_engine_pkg::fifo_prog_thresh));
    assign out.valid      = (count != '0);
    assign out.payload    = mem[rd_ptr];

    assign wr_en = in.valid && in.ready;
    assign rd_en = out.valid && out.ready;

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in.payload;
        end
    end

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // No write while full, judged by the pointers
    a_no_overflow : assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        wr_en |-> count == '0 || wr_ptr != rd_ptr);

    // No read while empty, judged by the pointers
    a_no_underflow : assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        rd_en |-> count == count_t'(DEPTH) || rd_ptr != wr_ptr);

endmodule : csr_sync_fifo

`default_nettype wire

// ==== common/csr_stream_if.sv ====
// Valid/ready stream between blocks of the configuration unit.
// Payload type is set per instance; the sink also reports almost full.

`timescale 1ns/100ps
`default_nettype none

interface csr_stream_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    payload_t payload;
    // Early back-pressure from the sink side
    logic     almost_full;

    modport source (
        output valid,
        output payload,
        input  ready,
        input  almost_full
    );

    modport sink (
        input  valid,
        input  payload,
        output ready,
        output almost_full
    );

endinterface : csr_stream_if

`default_nettype wire

// ==== common/csr_engine_pkg.sv ====
// Engine side definitions for the CSR index configuration unit.
// Sequence and FIFO constants, engine opcodes and the configuration record.

`default_nettype none

package csr_engine_pkg;

    // --------------------
    // Sequence and FIFO constants
    // --------------------
    localparam int seq_count        = 10;
    localparam int seq_w            = 4;
    localparam int fifo_depth       = 16;
    localparam int fifo_prog_thresh = 8;

    // One seen bit per sequence index
    typedef logic [seq_count-1:0] seq_mask_t;

    // --------------------
    // Engine opcodes
    // --------------------
    typedef enum logic [1:0] {
        op_location_0 = 2'd0,
        op_location_1 = 2'd1,
        op_location_2 = 2'd2,
        op_location_3 = 2'd3
    } engine_operand_e;

    typedef enum logic [2:0] {
        filter_nop = 3'd0,
        filter_gt  = 3'd1,
        filter_lt  = 3'd2,
        filter_eq  = 3'd3,
        filter_ne  = 3'd4,
        filter_ge  = 3'd5,
        filter_le  = 3'd6
    } filter_op_e;

    typedef enum logic [2:0] {
        alu_nop = 3'd0,
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_mul = 3'd3,
        alu_acc = 3'd4,
        alu_div = 3'd5
    } alu_op_e;

    // --------------------
    // Configuration record
    // --------------------
    typedef struct packed {
        logic                                increment;
        logic                                decrement;
        logic                                mode_sequence;
        logic                                mode_buffer;
        logic [csr_mem_pkg::data_w-1:0]      index_start;
        logic [csr_mem_pkg::data_w-1:0]      index_end;
        logic [csr_mem_pkg::data_w-1:0]      stride;
        logic [csr_mem_pkg::data_w-2:0]      granularity;
        logic                                shift_right;
        csr_mem_pkg::memory_cmd_e            cmd;
        csr_mem_pkg::buffer_kind_e           buffer;
        engine_operand_e                     operand;
        filter_op_e                          filter;
        alu_op_e                             alu;
        logic [csr_mem_pkg::addr_w-1:0]      array_pointer;
        logic [csr_mem_pkg::data_w-1:0]      array_size;
    } csr_index_config_t;

endpackage : csr_engine_pkg

`default_nettype wire

// ==== common/csr_mem_pkg.sv ====
// Memory side definitions shared by the CSR index configuration unit.
// Response field widths, buffer kinds, commands and the kept word format.

`default_nettype none

package csr_mem_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int data_w   = 32;
    localparam int offset_w = 32;
    localparam int shift_w  = 5;
    localparam int addr_w   = 64;

    // --------------------
    // Encodings
    // --------------------
    // Kind of buffer a response word belongs to
    typedef enum logic [2:0] {
        buf_invalid      = 3'd0,
        buf_cu_setup     = 3'd1,
        buf_engine_setup = 3'd2,
        buf_in_edges     = 3'd3,
        buf_out_edges    = 3'd4,
        buf_auxiliary    = 3'd5
    } buffer_kind_e;

    typedef enum logic [1:0] {
        cmd_invalid = 2'd0,
        cmd_read    = 2'd1,
        cmd_write   = 2'd2,
        cmd_stream  = 2'd3
    } memory_cmd_e;

    // --------------------
    // Kept setup word
    // --------------------
    // Index width is the engine sequence width (4 bits)
    typedef struct packed {
        logic [3:0]        seq_index;
        logic [data_w-1:0] data;
    } seq_word_t;

endpackage : csr_mem_pkg

`default_nettype wire
